// ==== Bender.yml ====
package:
  name: segre_mem

sources:
  - files:
      - hdl/segre_pkg.sv
      - hdl/segre_mem_align.sv
      - hdl/segre_store_buffer.sv
      - hdl/segre_mem_lookup.sv
      - hdl/segre_dmem.sv
      - hdl/segre_load_wb.sv
      - hdl/segre_mem_top.sv
  - target: test
    files:
      - testbench/segre_mem_tb.sv

// ==== hdl/segre_dmem.sv ====
`timescale 1ns/1ps

module segre_dmem (
    input  logic                                    clk_i,
    input  logic                                    re_i,
    input  logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    raddr_i,
    output logic [segre_pkg::WORD_SIZE-1:0]         rdata_o,
    input  logic                                    we_i,
    input  logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    waddr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]         wdata_i,
    input  logic [segre_pkg::MASK_SIZE-1:0]         wmask_i
);
    import segre_pkg::*;

    logic [WORD_SIZE-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < MASK_SIZE; b++) begin
                if (wmask_i[b]) mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // read data holds until the next read, writeback relies on that under stall
    always_ff @(posedge clk_i) begin
        if (re_i) rdata_o <= mem[raddr_i];
    end

    // single port, lookup and the buffer drain must never collide
    a_single_port: assert property (@(posedge clk_i) !(re_i && we_i));

endmodule

// ==== hdl/segre_load_wb.sv ====
`timescale 1ns/1ps

module segre_load_wb (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                l_valid_i,
    output logic                                l_ready_o,
    input  segre_pkg::wb_src_e                  l_src_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     l_fwd_data_i,
    input  logic [segre_pkg::LANE_SIZE-1:0]     l_lane_i,
    input  segre_pkg::memop_data_type_e         l_type_i,
    input  logic                                l_signed_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     ram_rdata_i,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [segre_pkg::WORD_SIZE-1:0]     rsp_data_o
);
    import segre_pkg::*;

    logic [WORD_SIZE-1:0] word;
    logic [WORD_SIZE-1:0] shifted;   // requested lane moved to bit 0
    logic                 ext_bit;

    // the lookup register is the response register, it only moves on a transfer
    assign rsp_valid_o = l_valid_i;
    assign l_ready_o   = rsp_ready_i;

    assign word    = (l_src_i == SRC_FWD) ? l_fwd_data_i : ram_rdata_i;
    assign shifted = word >> {l_lane_i, 3'b000};

    always_comb begin
        case (l_type_i)
            BYTE: begin
                ext_bit    = l_signed_i && shifted[7];
                rsp_data_o = {{(WORD_SIZE-8){ext_bit}}, shifted[7:0]};
            end
            HALF: begin
                ext_bit    = l_signed_i && shifted[15];
                rsp_data_o = {{(WORD_SIZE-16){ext_bit}}, shifted[15:0]};
            end
            default: begin
                ext_bit    = 1'b0;    // full word, nothing to extend
                rsp_data_o = shifted;
            end
        endcase
    end

    // a stalled response must not change, ram read data included
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_data_o)));

endmodule

// ==== hdl/segre_mem_align.sv ====
`timescale 1ns/1ps

module segre_mem_align (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    input  segre_pkg::memop_e                    req_op_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]      req_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]      req_data_i,
    input  segre_pkg::memop_data_type_e          req_type_i,
    input  logic                                 req_signed_i,
    output logic                                 a_valid_o,
    input  logic                                 a_ready_i,
    output segre_pkg::memop_e                    a_op_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]      a_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]      a_data_o,
    output logic [segre_pkg::MASK_SIZE-1:0]      a_mask_o,
    output segre_pkg::memop_data_type_e          a_type_o,
    output logic                                 a_signed_o,
    output logic                                 err_o
);
    import segre_pkg::*;

    logic [LANE_SIZE-1:0] lane;       // byte offset of the access
    logic [MASK_SIZE-1:0] mask;
    logic                 misaligned;
    logic                 req_fire;

    assign lane        = req_addr_i[LANE_SIZE-1:0];
    assign req_ready_o = !a_valid_o || a_ready_i;   // room when empty or being taken
    assign req_fire    = req_valid_i && req_ready_o;

    // alignment check and byte mask per access size
    always_comb begin
        case (req_type_i)
            BYTE: begin
                misaligned = 1'b0;                   // any offset is fine
                mask       = MASK_SIZE'(1) << lane;
            end
            HALF: begin
                misaligned = lane[0];                // must sit on an even byte
                mask       = MASK_SIZE'(3) << lane;
            end
            default: begin
                misaligned = (lane != '0);
                mask       = '1;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            a_valid_o <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            err_o <= req_fire && misaligned;         // one-cycle pulse, request dropped
            if (req_fire && !misaligned) a_valid_o <= 1'b1;
            else if (a_ready_i)          a_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire && !misaligned) begin
            a_op_o     <= req_op_i;
            a_addr_o   <= req_addr_i;
            a_data_o   <= req_data_i << {lane, 3'b000};  // store data into its lane
            a_mask_o   <= mask;
            a_type_o   <= req_type_i;
            a_signed_o <= req_signed_i;
        end
    end

    // only aligned requests with a real mask reach lookup
    a_mask_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
        a_valid_o |-> (a_mask_o != '0));

endmodule

// ==== hdl/segre_mem_lookup.sv ====
`timescale 1ns/1ps

module segre_mem_lookup (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    a_valid_i,
    output logic                                    a_ready_o,
    input  segre_pkg::memop_e                       a_op_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]         a_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]         a_data_i,
    input  logic [segre_pkg::MASK_SIZE-1:0]         a_mask_i,
    input  segre_pkg::memop_data_type_e             a_type_i,
    input  logic                                    a_signed_i,
    // store buffer write and probe
    output logic                                    st_valid_o,
    output logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    st_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]         st_data_o,
    output logic [segre_pkg::MASK_SIZE-1:0]         st_mask_o,
    output logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    ld_addr_o,
    output logic [segre_pkg::MASK_SIZE-1:0]         ld_mask_o,
    input  logic                                    full_i,
    input  logic                                    hit_i,
    input  logic                                    overlap_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]         fwd_data_i,
    // data ram port arbitration
    output logic                                    ram_re_o,
    output logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    ram_addr_o,
    output logic                                    drain_grant_o,
    // to writeback
    output logic                                    l_valid_o,
    input  logic                                    l_ready_i,
    output segre_pkg::wb_src_e                      l_src_o,
    output logic [segre_pkg::WORD_SIZE-1:0]         l_fwd_data_o,
    output logic [segre_pkg::LANE_SIZE-1:0]         l_lane_o,
    output segre_pkg::memop_data_type_e             l_type_o,
    output logic                                    l_signed_o
);
    import segre_pkg::*;

    logic [DMEM_ADDR_SIZE-1:0] word_addr;
    logic is_store;
    logic merge;      // store word already held in the buffer
    logic l_free;
    logic load_go;

    assign word_addr = a_addr_i[DMEM_ADDR_SIZE+LANE_SIZE-1:LANE_SIZE];
    assign is_store  = (a_op_i == OP_STORE);
    assign merge     = hit_i || overlap_i;     // full-mask probe, any held byte means a match
    assign l_free    = !l_valid_o || l_ready_i;

    // stores wait only on a full buffer, loads on overlap or a busy writeback
    assign a_ready_o = is_store ? (!full_i || merge) : (!overlap_i && l_free);
    assign load_go   = a_valid_i && !is_store && a_ready_o;

    assign st_valid_o = a_valid_i && is_store && a_ready_o;
    assign st_addr_o  = word_addr;
    assign st_data_o  = a_data_i;
    assign st_mask_o  = a_mask_i;
    assign ld_addr_o  = word_addr;
    assign ld_mask_o  = is_store ? '1 : a_mask_i;

    assign ram_re_o      = load_go && !hit_i;  // forwarded loads leave the port free
    assign ram_addr_o    = word_addr;
    assign drain_grant_o = !ram_re_o;

    always_ff @(posedge clk_i) begin
        if (rst_i)          l_valid_o <= 1'b0;
        else if (load_go)   l_valid_o <= 1'b1;
        else if (l_ready_i) l_valid_o <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (load_go) begin
            l_src_o      <= hit_i ? SRC_FWD : SRC_RAM;
            l_fwd_data_o <= fwd_data_i;
            l_lane_o     <= a_addr_i[LANE_SIZE-1:0];
            l_type_o     <= a_type_i;
            l_signed_o   <= a_signed_i;
        end
    end

endmodule

// ==== hdl/segre_mem_top.sv ====
`timescale 1ns/1ps

module segre_mem_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  segre_pkg::memop_e                   req_op_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]     req_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     req_data_i,
    input  segre_pkg::memop_data_type_e         req_type_i,
    input  logic                                req_signed_i,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [segre_pkg::WORD_SIZE-1:0]     rsp_data_o,
    output logic                                err_o
);
    import segre_pkg::*;

    // align to lookup
    logic                 a_valid, a_ready, a_signed;
    memop_e               a_op;
    logic [ADDR_SIZE-1:0] a_addr;
    logic [WORD_SIZE-1:0] a_data;
    logic [MASK_SIZE-1:0] a_mask;
    memop_data_type_e     a_type;

    // lookup and store buffer
    logic                      st_valid, full, hit, overlap;
    logic [DMEM_ADDR_SIZE-1:0] st_addr, ld_addr;
    logic [WORD_SIZE-1:0]      st_data, fwd_data;
    logic [MASK_SIZE-1:0]      st_mask, ld_mask;

    // data ram ports
    logic                      ram_re, drain_grant, drain_valid;
    logic [DMEM_ADDR_SIZE-1:0] ram_addr, drain_addr;
    logic [WORD_SIZE-1:0]      ram_rdata, drain_data;
    logic [MASK_SIZE-1:0]      drain_mask;

    // lookup to writeback
    logic                 l_valid, l_ready, l_signed;
    wb_src_e              l_src;
    logic [WORD_SIZE-1:0] l_fwd_data;
    logic [LANE_SIZE-1:0] l_lane;
    memop_data_type_e     l_type;

    segre_mem_align align0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
        .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_type_i(req_type_i),
        .req_signed_i(req_signed_i),
        .a_valid_o(a_valid), .a_ready_i(a_ready), .a_op_o(a_op), .a_addr_o(a_addr),
        .a_data_o(a_data), .a_mask_o(a_mask), .a_type_o(a_type), .a_signed_o(a_signed),
        .err_o(err_o)
    );

    segre_mem_lookup lookup0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .a_valid_i(a_valid), .a_ready_o(a_ready), .a_op_i(a_op), .a_addr_i(a_addr),
        .a_data_i(a_data), .a_mask_i(a_mask), .a_type_i(a_type), .a_signed_i(a_signed),
        .st_valid_o(st_valid), .st_addr_o(st_addr), .st_data_o(st_data),
        .st_mask_o(st_mask), .ld_addr_o(ld_addr), .ld_mask_o(ld_mask),
        .full_i(full), .hit_i(hit), .overlap_i(overlap), .fwd_data_i(fwd_data),
        .ram_re_o(ram_re), .ram_addr_o(ram_addr), .drain_grant_o(drain_grant),
        .l_valid_o(l_valid), .l_ready_i(l_ready), .l_src_o(l_src),
        .l_fwd_data_o(l_fwd_data), .l_lane_o(l_lane), .l_type_o(l_type),
        .l_signed_o(l_signed)
    );

    segre_store_buffer sbuf0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .st_valid_i(st_valid), .st_addr_i(st_addr), .st_data_i(st_data),
        .st_mask_i(st_mask), .full_o(full),
        .ld_addr_i(ld_addr), .ld_mask_i(ld_mask), .hit_o(hit), .overlap_o(overlap),
        .fwd_data_o(fwd_data),
        .drain_grant_i(drain_grant), .drain_valid_o(drain_valid),
        .drain_addr_o(drain_addr), .drain_data_o(drain_data), .drain_mask_o(drain_mask)
    );

    segre_dmem dmem0 (
        .clk_i(clk_i),
        .re_i(ram_re), .raddr_i(ram_addr), .rdata_o(ram_rdata),
        .we_i(drain_valid), .waddr_i(drain_addr), .wdata_i(drain_data),
        .wmask_i(drain_mask)
    );

    segre_load_wb wb0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .l_valid_i(l_valid), .l_ready_o(l_ready), .l_src_i(l_src),
        .l_fwd_data_i(l_fwd_data), .l_lane_i(l_lane), .l_type_i(l_type),
        .l_signed_i(l_signed), .ram_rdata_i(ram_rdata),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_data_o(rsp_data_o)
    );

endmodule

// ==== hdl/segre_pkg.sv ====
package segre_pkg;

    // datapath widths
    localparam int ADDR_SIZE = 16;              // byte address
    localparam int WORD_SIZE = 32;
    localparam int MASK_SIZE = WORD_SIZE / 8;   // bytes per word
    localparam int LANE_SIZE = $clog2(MASK_SIZE); // byte offset bits inside a word

    // store buffer
    localparam int SB_DEPTH    = 4;
    localparam int SB_PTR_SIZE = $clog2(SB_DEPTH); // head/tail wrap naturally

    // data ram, indexed by the low word-address bits only
    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_ADDR_SIZE = $clog2(DMEM_WORDS);

    // access size, sign handled by a separate flag
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } memop_e;

    // where the writeback word comes from
    typedef enum logic {
        SRC_FWD = 1'b0,   // store buffer forward
        SRC_RAM = 1'b1    // data ram read port
    } wb_src_e;

endpackage

// ==== hdl/segre_store_buffer.sv ====
`timescale 1ns/1ps

module segre_store_buffer (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    // store write from lookup
    input  logic                                    st_valid_i,
    input  logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    st_addr_i,   // word index
    input  logic [segre_pkg::WORD_SIZE-1:0]         st_data_i,
    input  logic [segre_pkg::MASK_SIZE-1:0]         st_mask_i,
    output logic                                    full_o,
    // load probe
    input  logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    ld_addr_i,
    input  logic [segre_pkg::MASK_SIZE-1:0]         ld_mask_i,
    output logic                                    hit_o,
    output logic                                    overlap_o,
    output logic [segre_pkg::WORD_SIZE-1:0]         fwd_data_o,
    // drain into the data ram
    input  logic                                    drain_grant_i,
    output logic                                    drain_valid_o,
    output logic [segre_pkg::DMEM_ADDR_SIZE-1:0]    drain_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]         drain_data_o,
    output logic [segre_pkg::MASK_SIZE-1:0]         drain_mask_o
);
    import segre_pkg::*;

    logic [SB_DEPTH-1:0]       ent_valid;
    logic [DMEM_ADDR_SIZE-1:0] ent_addr [SB_DEPTH];
    logic [WORD_SIZE-1:0]      ent_data [SB_DEPTH];
    logic [MASK_SIZE-1:0]      ent_mask [SB_DEPTH];

    logic [SB_PTR_SIZE-1:0] head;    // next free slot
    logic [SB_PTR_SIZE-1:0] tail;    // oldest entry

    logic [SB_DEPTH-1:0]  st_match;  // entries holding the store's word
    logic [SB_DEPTH-1:0]  st_merge;  // same, minus an entry leaving this cycle
    logic [SB_DEPTH-1:0]  ld_match;
    logic [MASK_SIZE-1:0] ld_cov;    // bytes the matching entry holds
    logic                 drain_fire;
    logic                 dup_addr;

    assign full_o     = &ent_valid;
    assign drain_fire = drain_grant_i && ent_valid[tail];  // entries are contiguous from tail

    assign drain_valid_o = drain_fire;   // ram write strobe
    assign drain_addr_o  = ent_addr[tail];
    assign drain_data_o  = ent_data[tail];
    assign drain_mask_o  = ent_mask[tail];

    // word match for the store and for the load probe
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            st_match[i] = ent_valid[i] && (ent_addr[i] == st_addr_i);
            ld_match[i] = ent_valid[i] && (ent_addr[i] == ld_addr_i);
        end
        st_merge = st_match;
        // merging into the draining entry would lose bytes, take a new slot instead
        if (drain_fire) st_merge[tail] = 1'b0;
    end

    // at most one entry per word, so a plain mux is enough
    always_comb begin
        fwd_data_o = '0;
        ld_cov     = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (ld_match[i]) begin
                fwd_data_o = ent_data[i];
                ld_cov     = ent_mask[i];
            end
        end
        hit_o     = (|ld_match) && ((ld_mask_i & ~ld_cov) == '0);  // every byte covered
        overlap_o = (|(ld_mask_i & ld_cov)) && !hit_o;             // only some bytes
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            if (drain_fire) begin
                ent_valid[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            // allocate after the drain so a full buffer can refill the freed slot
            if (st_valid_i && !(|st_merge)) begin
                ent_valid[head] <= 1'b1;
                head            <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (st_valid_i) begin
            if (|st_merge) begin
                for (int i = 0; i < SB_DEPTH; i++) begin
                    if (st_merge[i]) begin
                        for (int b = 0; b < MASK_SIZE; b++) begin
                            if (st_mask_i[b]) ent_data[i][b*8 +: 8] <= st_data_i[b*8 +: 8];
                        end
                        ent_mask[i] <= ent_mask[i] | st_mask_i;   // accumulate bytes
                    end
                end
            end else begin
                ent_addr[head] <= st_addr_i;
                ent_data[head] <= st_data_i;
                ent_mask[head] <= st_mask_i;
            end
        end
    end

    always_comb begin
        dup_addr = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            for (int j = i + 1; j < SB_DEPTH; j++) begin
                if (ent_valid[i] && ent_valid[j] && (ent_addr[i] == ent_addr[j])) begin
                    dup_addr = 1'b1;
                end
            end
        end
    end

    a_unique_words: assert property (@(posedge clk_i) disable iff (rst_i) !dup_addr);

    // lookup only writes a full buffer when the word is already held
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        (st_valid_i && full_o) |-> (|st_match));

endmodule

// ==== segre_mem.f ====
hdl/segre_pkg.sv
hdl/segre_mem_align.sv
hdl/segre_store_buffer.sv
hdl/segre_mem_lookup.sv
hdl/segre_dmem.sv
hdl/segre_load_wb.sv
hdl/segre_mem_top.sv
testbench/segre_mem_tb.sv

// ==== testbench/segre_mem_tb.sv ====
`timescale 1ns/1ps

module segre_mem_tb;
    import segre_pkg::*;

    localparam int WINDOW  = 32;    // small byte window so hits and overlaps are common
    localparam int TIMEOUT = 1000;  // cycles allowed per wait

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    memop_e               req_op_i;
    logic [ADDR_SIZE-1:0] req_addr_i;
    logic [WORD_SIZE-1:0] req_data_i;
    memop_data_type_e     req_type_i;
    logic                 req_signed_i;
    logic                 rsp_valid_o;
    logic                 rsp_ready_i;
    logic [WORD_SIZE-1:0] rsp_data_o;
    logic                 err_o;

    logic [7:0]           model [WINDOW];   // reference byte memory
    logic [WORD_SIZE-1:0] exp_q [$];        // expected load results in load order
    bit                   fwd_q [$];        // set per load that must come from the buffer
    bit                   fwd_next;         // tag for the next load sent
    bit                   err_exp;
    bit                   bp_on;            // random back-pressure on the response
    bit                   stall_seen;
    string                test_name;

    segre_mem_top dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
        .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_type_i(req_type_i),
        .req_signed_i(req_signed_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_data_o(rsp_data_o),
        .err_o(err_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic int size_of(memop_data_type_e t);
        case (t)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic bit is_misaligned(memop_data_type_e t, logic [ADDR_SIZE-1:0] a);
        return (a % size_of(t)) != 0;
    endfunction

    function automatic memop_data_type_e rand_type();
        case ($urandom % 3)
            0:       return BYTE;
            1:       return HALF;
            default: return WORD;
        endcase
    endfunction

    // little endian read of the model with sign or zero fill
    function automatic logic [WORD_SIZE-1:0] load_expect(memop_data_type_e t,
            logic [ADDR_SIZE-1:0] a, bit sgn);
        logic [WORD_SIZE-1:0] v;
        int n;
        n = size_of(t);
        v = '0;
        for (int i = 0; i < n; i++) v[i*8 +: 8] = model[(a + i) % WINDOW];
        if (sgn && v[n*8-1]) begin
            for (int b = n * 8; b < WORD_SIZE; b++) v[b] = 1'b1;
        end
        return v;
    endfunction

    task automatic model_store(memop_data_type_e t, logic [ADDR_SIZE-1:0] a,
            logic [WORD_SIZE-1:0] d);
        for (int i = 0; i < size_of(t); i++) model[(a + i) % WINDOW] = d[i*8 +: 8];
    endtask

    task automatic stop_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rsp(string name, logic [WORD_SIZE-1:0] exp,
            logic [WORD_SIZE-1:0] act);
        if (act !== exp) stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_err(string name, bit exp, bit act);
        if (act != exp) stop_run($sformatf("FAILED %s: expected %0b, actual %0b", name, exp, act));
    endtask

    task automatic check_src(string name, wb_src_e exp, wb_src_e act);
        if (act != exp) begin
            stop_run($sformatf("FAILED %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    // drives one request and holds it until it transfers
    task automatic send(memop_e op, memop_data_type_e t, logic [ADDR_SIZE-1:0] a,
            logic [WORD_SIZE-1:0] d, bit sgn);
        int waited;
        req_op_i     = op;
        req_type_i   = t;
        req_addr_i   = a;
        req_data_i   = d;
        req_signed_i = sgn;
        req_valid_i  = 1'b1;
        waited       = 0;
        do begin
            @(posedge clk_i);
            if (!req_ready_o) stall_seen = 1'b1;
            waited++;
            if (waited > TIMEOUT) stop_run("request was not accepted before the timeout");
        end while (!req_ready_o);
        @(negedge clk_i);
        req_valid_i = 1'b0;
        fwd_next    = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) stop_run("load responses still missing after the timeout");
        end
    endtask

    // scoreboard sees every transfer on the edge where it happens
    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) stop_run("a response arrived with no load outstanding");
                if (fwd_q[0]) check_src(test_name, SRC_FWD, dut0.l_src);
                check_rsp(test_name, exp_q[0], rsp_data_o);
                exp_q.delete(0);
                fwd_q.delete(0);
            end
            check_err({test_name, " err_o"}, err_exp, err_o);
            err_exp = 1'b0;
            if (req_valid_i && req_ready_o) begin
                if (is_misaligned(req_type_i, req_addr_i)) begin
                    err_exp = 1'b1;                       // dropped without touching the model
                end else if (req_op_i == OP_STORE) begin
                    model_store(req_type_i, req_addr_i, req_data_i);
                end else begin
                    exp_q.push_back(load_expect(req_type_i, req_addr_i, req_signed_i));
                    fwd_q.push_back(fwd_next);
                end
            end
        end
    end

    always @(negedge clk_i) begin
        if (bp_on) rsp_ready_i = ($urandom % 4) != 0;    // ready about 3 cycles in 4
    end

    initial begin
        logic [ADDR_SIZE-1:0] a;
        logic [WORD_SIZE-1:0] d;
        memop_data_type_e     t;
        memop_e               op;
        void'($urandom(44));
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_op_i     = OP_LOAD;
        req_addr_i   = '0;
        req_data_i   = '0;
        req_type_i   = WORD;
        req_signed_i = 1'b0;
        rsp_ready_i  = 1'b1;
        test_name    = "reset";
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        if (!req_ready_o || rsp_valid_o || err_o) stop_run("outputs are not idle after reset");

        // fill every word and read it back with writeback stalled so the pipe backs up
        test_name   = "store_burst";
        stall_seen  = 1'b0;
        rsp_ready_i = 1'b0;
        fork
            begin
                repeat (40) @(negedge clk_i);
                rsp_ready_i = 1'b1;
            end
        join_none
        for (int w = 0; w < WINDOW / MASK_SIZE; w++) send(OP_STORE, WORD, ADDR_SIZE'(w * 4),
            $urandom, 1'b0);
        for (int w = 0; w < WINDOW / MASK_SIZE; w++) send(OP_LOAD, WORD, ADDR_SIZE'(w * 4),
            '0, 1'b0);
        if (!stall_seen) stop_run("req_ready_o never dropped while writeback was stalled");
        wait_responses();

        test_name = "store_load_forward";
        for (int k = 0; k < 8; k++) begin
            a = ADDR_SIZE'(($urandom % (WINDOW / MASK_SIZE)) * 4);
            d = $urandom;
            send(OP_STORE, WORD, a, d, 1'b0);
            fwd_next = 1'b1;                    // still in the buffer when probed
            send(OP_LOAD, WORD, a, '0, 1'b0);
        end
        wait_responses();

        test_name = "narrow_loads";
        for (int b = 0; b < WINDOW; b++) begin
            send(OP_LOAD, BYTE, ADDR_SIZE'(b), '0, 1'b0);
            send(OP_LOAD, BYTE, ADDR_SIZE'(b), '0, 1'b1);
            if (b % 2 == 0) begin
                send(OP_LOAD, HALF, ADDR_SIZE'(b), '0, 1'b0);
                send(OP_LOAD, HALF, ADDR_SIZE'(b), '0, 1'b1);
            end
        end
        wait_responses();

        test_name = "merge_overlap";
        send(OP_STORE, BYTE, 16'd8, 32'h0000_0081, 1'b0);
        send(OP_STORE, BYTE, 16'd9, 32'h0000_007e, 1'b0);
        send(OP_STORE, HALF, 16'd10, 32'h0000_c3a5, 1'b0);
        send(OP_LOAD, WORD, 16'd8, '0, 1'b0);           // merged entry
        send(OP_STORE, BYTE, 16'd17, 32'h0000_009c, 1'b0);
        send(OP_LOAD, HALF, 16'd16, '0, 1'b1);          // partial overlap waits for the drain
        send(OP_LOAD, WORD, 16'd16, '0, 1'b0);
        wait_responses();

        test_name = "misaligned";
        send(OP_STORE, WORD, 16'd20, 32'h1234_5678, 1'b0);
        send(OP_STORE, WORD, 16'd22, 32'hdead_beef, 1'b0);
        send(OP_LOAD, HALF, 16'd21, '0, 1'b1);          // no response expected
        send(OP_LOAD, WORD, 16'd20, '0, 1'b0);
        send(OP_STORE, HALF, 16'd27, 32'h0000_ffff, 1'b0);
        send(OP_LOAD, WORD, 16'd24, '0, 1'b0);
        wait_responses();

        test_name = "random_mix";
        bp_on     = 1'b1;
        for (int n = 0; n < 2000; n++) begin
            t = rand_type();
            a = ADDR_SIZE'($urandom % WINDOW);
            if (($urandom % 32) != 0) a = a & ~(ADDR_SIZE'(size_of(t) - 1));  // mostly aligned
            op = (($urandom % 2) != 0) ? OP_STORE : OP_LOAD;
            send(op, t, a, $urandom, ($urandom % 2) != 0);
            if (($urandom % 8) == 0) @(negedge clk_i);  // idle gap
        end
        bp_on       = 1'b0;
        rsp_ready_i = 1'b1;
        wait_responses();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
